// ==== mips_pkg.sv ====
`default_nettype none

package mips_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	// Instruction addresses count words, not bytes
	typedef logic [7:0]  pc_t;

	localparam int REG_COUNT  = 32;
	localparam int DMEM_WORDS = 256;
	localparam int DMEM_AW    = $clog2(DMEM_WORDS);

	// Primary opcodes
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_ADDI  = 6'h08;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2b;
	localparam logic [5:0] OP_BEQ   = 6'h04;
	localparam logic [5:0] OP_J     = 6'h02;

	// R-type funct field
	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR  = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT
	} alu_op_e;

	typedef enum logic [1:0] {
		FWD_REG,
		FWD_MEM,
		FWD_WB
	} fwd_sel_e;

	// All zero means no-op
	typedef struct packed {
		logic    reg_write;
		logic    mem_read;
		logic    mem_write;
		logic    mem_to_reg;
		logic    branch;
		logic    jmp;
		logic    alu_src;
		alu_op_e alu_op;
	} ctrl_t;

	typedef struct packed {
		word_t instr;
		pc_t   pc;
	} fd_t;

	typedef struct packed {
		ctrl_t     ctrl;
		pc_t       pc;
		word_t     rs_val;
		word_t     rt_val;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t dst;
		word_t     imm;
		pc_t       jmp_target;
	} dx_t;

	typedef struct packed {
		ctrl_t     ctrl;
		word_t     alu;
		logic      zero;
		word_t     store_data;
		reg_addr_t rt;
		reg_addr_t dst;
		pc_t       br_target;
		pc_t       jmp_target;
	} xm_t;

	typedef struct packed {
		logic      reg_write;
		logic      mem_to_reg;
		word_t     alu;
		word_t     rdata;
		reg_addr_t dst;
	} mw_t;

	typedef struct packed {
		logic      we;
		reg_addr_t dst;
		word_t     val;
	} wb_t;

endpackage

`default_nettype wire

// ==== mips_fetch.sv ====
`default_nettype none

module mips_fetch import mips_pkg::*; (
	input  logic clk_i,
	input  logic rst_n_i,
	input  logic stall_i,
	input  logic squash_i,
	input  pc_t  target_i,
	output pc_t  pc_o
);

	pc_t pc_q;

	// Redirect beats stall, stall beats increment
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			pc_q <= '0;
		end else if (squash_i) begin
			pc_q <= target_i;
		end else if (!stall_i) begin
			pc_q <= pc_q + 8'd1;
		end
	end

	assign pc_o = pc_q;

endmodule

`default_nettype wire

// ==== mips_decode.sv ====
`default_nettype none

module mips_decode import mips_pkg::*; (
	input  logic clk_i,
	input  logic rst_n_i,
	input  fd_t  fd_i,
	input  mw_t  mw_i,
	output dx_t  dx_o,
	output wb_t  wb_o
);

	logic [5:0] opcode;
	logic [5:0] funct;
	reg_addr_t  rs;
	reg_addr_t  rt;
	reg_addr_t  rd;
	ctrl_t      ctrl;
	reg_addr_t  dst;
	word_t      regs [REG_COUNT];

	assign opcode = fd_i.instr[31:26];
	assign rs     = fd_i.instr[25:21];
	assign rt     = fd_i.instr[20:16];
	assign rd     = fd_i.instr[15:11];
	assign funct  = fd_i.instr[5:0];

	// Main controller
	always_comb begin
		ctrl = '0;
		dst  = rd;
		case (opcode)
			OP_RTYPE: begin
				ctrl.reg_write = 1'b1;
				case (funct)
					FN_ADD:  ctrl.alu_op = ALU_ADD;
					FN_SUB:  ctrl.alu_op = ALU_SUB;
					FN_AND:  ctrl.alu_op = ALU_AND;
					FN_OR:   ctrl.alu_op = ALU_OR;
					FN_SLT:  ctrl.alu_op = ALU_SLT;
					default: ctrl = '0;
				endcase
			end
			OP_ADDI: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src   = 1'b1;
				dst            = rt;
			end
			OP_LW: begin
				ctrl.reg_write  = 1'b1;
				ctrl.mem_read   = 1'b1;
				ctrl.mem_to_reg = 1'b1;
				ctrl.alu_src    = 1'b1;
				dst             = rt;
			end
			OP_SW: begin
				ctrl.mem_write = 1'b1;
				ctrl.alu_src   = 1'b1;
			end
			OP_BEQ: begin
				ctrl.branch = 1'b1;
				ctrl.alu_op = ALU_SUB;
			end
			OP_J:    ctrl.jmp = 1'b1;
			default: ctrl = '0;
		endcase
	end

	// Writeback select, r0 never reported as written
	always_comb begin
		wb_o.we  = mw_i.reg_write && (mw_i.dst != '0);
		wb_o.dst = mw_i.dst;
		wb_o.val = mw_i.mem_to_reg ? mw_i.rdata : mw_i.alu;
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_o.we) begin
			regs[wb_o.dst] <= wb_o.val;
		end
	end

	// Reads see a same-cycle write
	always_comb begin
		dx_o.ctrl       = ctrl;
		dx_o.pc         = fd_i.pc;
		dx_o.rs         = rs;
		dx_o.rt         = rt;
		dx_o.dst        = dst;
		dx_o.imm        = {{16{fd_i.instr[15]}}, fd_i.instr[15:0]};
		dx_o.jmp_target = fd_i.instr[7:0];
		if (rs == '0)
			dx_o.rs_val = '0;
		else if (wb_o.we && wb_o.dst == rs)
			dx_o.rs_val = wb_o.val;
		else
			dx_o.rs_val = regs[rs];
		if (rt == '0)
			dx_o.rt_val = '0;
		else if (wb_o.we && wb_o.dst == rt)
			dx_o.rt_val = wb_o.val;
		else
			dx_o.rt_val = regs[rt];
	end

endmodule

`default_nettype wire

// ==== mips_stage_reg.sv ====
`default_nettype none

module mips_stage_reg #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     clk_i,
	input  logic     rst_n_i,
	input  logic     hold_i,
	input  logic     bubble_i,
	input  payload_t d_i,
	output payload_t q_o
);

	// A bubble wins over hold so a squash always clears the stage
	always_ff @(posedge clk_i) begin
		if (!rst_n_i || bubble_i) begin
			q_o <= '0;
		end else if (!hold_i) begin
			q_o <= d_i;
		end
	end

endmodule

`default_nettype wire

// ==== mips_hazard.sv ====
`default_nettype none

module mips_hazard import mips_pkg::*; (
	input  fd_t      fd_i,
	input  dx_t      dx_i,
	input  xm_t      xm_i,
	input  wb_t      wb_i,
	output logic     stall_o,
	output logic     squash_o,
	output pc_t      target_o,
	output fwd_sel_e fwd_a_o,
	output fwd_sel_e fwd_b_o,
	output logic     fwd_store_o
);

	reg_addr_t fd_rs;
	reg_addr_t fd_rt;
	logic      load_use;

	// Memory stage is younger, so it wins over writeback
	function automatic fwd_sel_e pick_src(reg_addr_t src, xm_t xm, wb_t wb);
		fwd_sel_e sel;
		sel = FWD_REG;
		if (src != '0) begin
			if (xm.ctrl.reg_write && xm.dst == src)
				sel = FWD_MEM;
			else if (wb.we && wb.dst == src)
				sel = FWD_WB;
		end
		return sel;
	endfunction

	assign fd_rs = fd_i.instr[25:21];
	assign fd_rt = fd_i.instr[20:16];

	assign load_use = dx_i.ctrl.mem_read && (dx_i.dst != '0) &&
		((dx_i.dst == fd_rs) || (dx_i.dst == fd_rt));

	assign squash_o = xm_i.ctrl.jmp || (xm_i.ctrl.branch && xm_i.zero);
	assign stall_o  = load_use && !squash_o;
	assign target_o = xm_i.ctrl.jmp ? xm_i.jmp_target : xm_i.br_target;

	assign fwd_a_o = pick_src(dx_i.rs, xm_i, wb_i);
	assign fwd_b_o = pick_src(dx_i.rt, xm_i, wb_i);

	// Store data still in flight at writeback
	assign fwd_store_o = xm_i.ctrl.mem_write && wb_i.we &&
		(xm_i.rt != '0) && (wb_i.dst == xm_i.rt);

endmodule

`default_nettype wire

// ==== mips_execute.sv ====
`default_nettype none

module mips_execute import mips_pkg::*; (
	input  dx_t      dx_i,
	input  fwd_sel_e fwd_a_i,
	input  fwd_sel_e fwd_b_i,
	input  word_t    mem_fwd_i,
	input  word_t    wb_fwd_i,
	output xm_t      xm_o
);

	word_t op_a;
	word_t rt_fwd;
	word_t op_b;
	word_t result;

	always_comb begin
		case (fwd_a_i)
			FWD_MEM: op_a = mem_fwd_i;
			FWD_WB:  op_a = wb_fwd_i;
			default: op_a = dx_i.rs_val;
		endcase
		case (fwd_b_i)
			FWD_MEM: rt_fwd = mem_fwd_i;
			FWD_WB:  rt_fwd = wb_fwd_i;
			default: rt_fwd = dx_i.rt_val;
		endcase
	end

	assign op_b = dx_i.ctrl.alu_src ? dx_i.imm : rt_fwd;

	always_comb begin
		case (dx_i.ctrl.alu_op)
			ALU_SUB: result = op_a - op_b;
			ALU_AND: result = op_a & op_b;
			ALU_OR:  result = op_a | op_b;
			// Signed compare
			ALU_SLT: result = {31'd0, $signed(op_a) < $signed(op_b)};
			default: result = op_a + op_b;
		endcase
	end

	always_comb begin
		xm_o.ctrl       = dx_i.ctrl;
		xm_o.alu        = result;
		xm_o.zero       = (result == '0);
		xm_o.store_data = rt_fwd;
		xm_o.rt         = dx_i.rt;
		xm_o.dst        = dx_i.dst;
		// pc already points past the branch
		xm_o.br_target  = dx_i.pc + dx_i.imm[7:0];
		xm_o.jmp_target = dx_i.jmp_target;
	end

endmodule

`default_nettype wire

// ==== mips_dmem.sv ====
`default_nettype none

module mips_dmem import mips_pkg::*; (
	input  logic  clk_i,
	input  xm_t   xm_i,
	input  logic  fwd_store_i,
	input  wb_t   wb_i,
	output mw_t   mw_o,
	output logic  dmem_we_o,
	output word_t dmem_addr_o,
	output word_t dmem_wdata_o
);

	word_t               mem [DMEM_WORDS];
	logic [DMEM_AW-1:0]  index;

	// Word index, byte offset dropped
	assign index = xm_i.alu[DMEM_AW+1:2];

	assign dmem_we_o    = xm_i.ctrl.mem_write;
	assign dmem_addr_o  = xm_i.alu;
	assign dmem_wdata_o = fwd_store_i ? wb_i.val : xm_i.store_data;

	always_ff @(posedge clk_i) begin
		if (dmem_we_o)
			mem[index] <= dmem_wdata_o;
	end

	always_comb begin
		mw_o.reg_write  = xm_i.ctrl.reg_write;
		mw_o.mem_to_reg = xm_i.ctrl.mem_to_reg;
		mw_o.alu        = xm_i.alu;
		mw_o.rdata      = mem[index];
		mw_o.dst        = xm_i.dst;
	end

endmodule

`default_nettype wire

// ==== mips_pipe_top.sv ====
`default_nettype none

module mips_pipe_top import mips_pkg::*; (
	input  logic      clk_i,
	input  logic      rst_n_i,
	output pc_t       imem_addr_o,
	input  word_t     imem_data_i,
	output logic      wb_valid_o,
	output reg_addr_t wb_dst_o,
	output word_t     wb_val_o,
	output logic      dmem_we_o,
	output word_t     dmem_addr_o,
	output word_t     dmem_wdata_o
);

	pc_t      pc;
	fd_t      fd_d, fd_q;
	dx_t      dx_d, dx_q;
	xm_t      xm_d, xm_q;
	mw_t      mw_d, mw_q;
	wb_t      wb;
	logic     stall;
	logic     squash;
	pc_t      target;
	fwd_sel_e fwd_a;
	fwd_sel_e fwd_b;
	logic     fwd_store;

	assign imem_addr_o = pc;
	assign fd_d.instr  = imem_data_i;
	assign fd_d.pc     = pc + 8'd1;

	assign wb_valid_o = wb.we;
	assign wb_dst_o   = wb.dst;
	assign wb_val_o   = wb.val;

	mips_fetch u_fetch (
		.clk_i    (clk_i),
		.rst_n_i  (rst_n_i),
		.stall_i  (stall),
		.squash_i (squash),
		.target_i (target),
		.pc_o     (pc)
	);

	// Held on a load-use stall
	mips_stage_reg #(.payload_t(fd_t)) u_fd_reg (
		.clk_i    (clk_i),
		.rst_n_i  (rst_n_i),
		.hold_i   (stall),
		.bubble_i (squash),
		.d_i      (fd_d),
		.q_o      (fd_q)
	);

	mips_decode u_decode (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.fd_i    (fd_q),
		.mw_i    (mw_q),
		.dx_o    (dx_d),
		.wb_o    (wb)
	);

	mips_stage_reg #(.payload_t(dx_t)) u_dx_reg (
		.clk_i    (clk_i),
		.rst_n_i  (rst_n_i),
		.hold_i   (1'b0),
		.bubble_i (stall | squash),
		.d_i      (dx_d),
		.q_o      (dx_q)
	);

	mips_hazard u_hazard (
		.fd_i        (fd_q),
		.dx_i        (dx_q),
		.xm_i        (xm_q),
		.wb_i        (wb),
		.stall_o     (stall),
		.squash_o    (squash),
		.target_o    (target),
		.fwd_a_o     (fwd_a),
		.fwd_b_o     (fwd_b),
		.fwd_store_o (fwd_store)
	);

	mips_execute u_execute (
		.dx_i      (dx_q),
		.fwd_a_i   (fwd_a),
		.fwd_b_i   (fwd_b),
		.mem_fwd_i (xm_q.alu),
		.wb_fwd_i  (wb.val),
		.xm_o      (xm_d)
	);

	mips_stage_reg #(.payload_t(xm_t)) u_xm_reg (
		.clk_i    (clk_i),
		.rst_n_i  (rst_n_i),
		.hold_i   (1'b0),
		.bubble_i (squash),
		.d_i      (xm_d),
		.q_o      (xm_q)
	);

	mips_dmem u_dmem (
		.clk_i        (clk_i),
		.xm_i         (xm_q),
		.fwd_store_i  (fwd_store),
		.wb_i         (wb),
		.mw_o         (mw_d),
		.dmem_we_o    (dmem_we_o),
		.dmem_addr_o  (dmem_addr_o),
		.dmem_wdata_o (dmem_wdata_o)
	);

	// Branch in MW never writes, so no bubble here
	mips_stage_reg #(.payload_t(mw_t)) u_mw_reg (
		.clk_i    (clk_i),
		.rst_n_i  (rst_n_i),
		.hold_i   (1'b0),
		.bubble_i (1'b0),
		.d_i      (mw_d),
		.q_o      (mw_q)
	);

endmodule

`default_nettype wire

// ==== mips_pipe_props.sv ====
`default_nettype none

module mips_pipe_props import mips_pkg::*; (
	input logic      clk_i,
	input logic      rst_n_i,
	input logic      wb_valid_i,
	input reg_addr_t wb_dst_i,
	input logic      dmem_we_i,
	input pc_t       imem_addr_i,
	input logic      stall_i,
	input logic      squash_i
);

	timeunit 1ns;
	timeprecision 1ps;

	a_no_r0_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wb_valid_i |-> wb_dst_i != '0)
		else $error("register write reported for r0");

	a_dmem_idle_in_reset: assert property (@(posedge clk_i)
		!rst_n_i |=> !dmem_we_i)
		else $error("data memory write right after a reset cycle");

	// First stores need three cycles to reach the memory stage
	a_dmem_idle_after_reset: assert property (@(posedge clk_i)
		!rst_n_i ##1 rst_n_i |=> !dmem_we_i ##1 !dmem_we_i)
		else $error("data memory write too soon after reset");

	a_pc_holds_on_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		stall_i && !squash_i |=> imem_addr_i == $past(imem_addr_i))
		else $error("fetch address moved during a stall");

endmodule

bind mips_pipe_top mips_pipe_props u_props (
	.clk_i       (clk_i),
	.rst_n_i     (rst_n_i),
	.wb_valid_i  (wb_valid_o),
	.wb_dst_i    (wb_dst_o),
	.dmem_we_i   (dmem_we_o),
	.imem_addr_i (imem_addr_o),
	.stall_i     (stall),
	.squash_i    (squash)
);

`default_nettype wire

// ==== tb_mips_pipe.sv ====
`default_nettype none

module tb_mips_pipe import mips_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	// Register write or store event
	typedef struct packed {
		logic  is_store;
		word_t addr;
		word_t val;
	} trace_t;

	logic      clk = 1'b0;
	logic      rst_n;
	pc_t       imem_addr;
	word_t     imem_data;
	logic      wb_valid;
	reg_addr_t wb_dst;
	word_t     wb_val;
	logic      dmem_we;
	word_t     dmem_addr;
	word_t     dmem_wdata;

	word_t     imem [256];
	word_t     model_mem [DMEM_WORDS];
	trace_t    exp_q [$];
	pc_t       load_ptr;
	logic      checking = 1'b0;
	int        cycle_count = 0;
	int        cycle_limit = 0;
	integer    seed;

	mips_pipe_top dut_i (
		.clk_i        (clk),
		.rst_n_i      (rst_n),
		.imem_addr_o  (imem_addr),
		.imem_data_i  (imem_data),
		.wb_valid_o   (wb_valid),
		.wb_dst_o     (wb_dst),
		.wb_val_o     (wb_val),
		.dmem_we_o    (dmem_we),
		.dmem_addr_o  (dmem_addr),
		.dmem_wdata_o (dmem_wdata)
	);

	always #4 clk = ~clk;

	// Instruction memory answers in the same cycle
	assign imem_data = imem[imem_addr];

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("Timeout after %0d cycles with %0d events still expected",
				cycle_count, exp_q.size());
			$display("tests failed");
			$fatal(1, "simulation ran past its cycle limit");
		end
	end

	task automatic check_value(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			$display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
			$display("tests failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic match_event(input logic is_store, input word_t addr, input word_t val);
		trace_t ev;
		if (exp_q.size() == 0) begin
			$display("The DUT made an extra %s at %0t after all expected events",
				is_store ? "store" : "register write", $time);
			$display("tests failed");
			$fatal(1, "unexpected event");
		end else begin
			ev = exp_q.pop_front();
			check_value({31'd0, is_store}, {31'd0, ev.is_store}, "event kind (1 is store)");
			check_value(addr, ev.addr, is_store ? "store address" : "write register");
			check_value(val, ev.val, is_store ? "store data" : "write value");
		end
	endtask

	// Older instruction sits in writeback, so it is compared first
	always @(negedge clk) begin
		if (checking && wb_valid)
			match_event(1'b0, {27'd0, wb_dst}, wb_val);
		if (checking && dmem_we)
			match_event(1'b1, dmem_addr, dmem_wdata);
	end

	function automatic word_t rtype_word(logic [5:0] fn, reg_addr_t rd, reg_addr_t rs,
		reg_addr_t rt);
		return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t itype_word(logic [5:0] op, reg_addr_t rt, reg_addr_t rs,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t jump_word(pc_t target);
		return {OP_J, 18'd0, target};
	endfunction

	task automatic put_instr(input word_t w);
		imem[load_ptr] = w;
		load_ptr = load_ptr + 8'd1;
	endtask

	task automatic expect_event(input logic is_store, input word_t addr, input word_t val);
		trace_t ev;
		ev.is_store = is_store;
		ev.addr     = addr;
		ev.val      = val;
		exp_q.push_back(ev);
	endtask

	// Executes the program in order until the self-jump
	task automatic run_model();
		word_t     regs [REG_COUNT];
		pc_t       pc;
		pc_t       npc;
		word_t     ins;
		word_t     a;
		word_t     b;
		word_t     imm;
		word_t     addr;
		word_t     res;
		reg_addr_t dst;
		logic      wr;
		int        steps;
		for (int i = 0; i < REG_COUNT; i++)
			regs[i] = '0;
		pc = '0;
		steps = 0;
		while (!(imem[pc][31:26] == OP_J && imem[pc][7:0] == pc) && steps < 1000) begin
			ins  = imem[pc];
			a    = regs[ins[25:21]];
			b    = regs[ins[20:16]];
			imm  = {{16{ins[15]}}, ins[15:0]};
			addr = a + imm;
			npc  = pc + 8'd1;
			dst  = ins[15:11];
			wr   = 1'b0;
			res  = '0;
			case (ins[31:26])
				OP_RTYPE: begin
					wr = 1'b1;
					case (ins[5:0])
						FN_ADD:  res = a + b;
						FN_SUB:  res = a - b;
						FN_AND:  res = a & b;
						FN_OR:   res = a | b;
						FN_SLT:  res = {31'd0, $signed(a) < $signed(b)};
						default: wr = 1'b0;
					endcase
				end
				OP_ADDI: begin
					wr  = 1'b1;
					dst = ins[20:16];
					res = addr;
				end
				OP_LW: begin
					wr  = 1'b1;
					dst = ins[20:16];
					res = model_mem[addr[DMEM_AW+1:2]];
				end
				OP_SW: begin
					model_mem[addr[DMEM_AW+1:2]] = b;
					expect_event(1'b1, addr, b);
				end
				OP_BEQ: begin
					if (a == b)
						npc = npc + imm[7:0];
				end
				OP_J:    npc = ins[7:0];
				default: wr = 1'b0;
			endcase
			if (wr && dst != '0) begin
				regs[dst] = res;
				expect_event(1'b0, {27'd0, dst}, res);
			end
			pc = npc;
			steps++;
		end
		cycle_limit += 3 * (steps + 1);
	endtask

	task automatic start_test(input string name);
		cycle_limit += 20;
		checking = 1'b0;
		$display("Running %s", name);
		for (int i = 0; i < 256; i++)
			imem[i] = '0;
		@(posedge clk);
		rst_n <= 1'b0;
		repeat (4) @(posedge clk);
		load_ptr = '0;
	endtask

	task automatic run_program();
		run_model();
		checking = 1'b1;
		rst_n <= 1'b1;
		while (exp_q.size() != 0)
			@(posedge clk);
		// Any stray write shows up while the self-jump spins
		repeat (4) @(posedge clk);
	endtask

	task automatic alu_chain();
		start_test("dependent ALU chain");
		put_instr(itype_word(OP_ADDI, 5'd1, 5'd0, 16'd5));
		put_instr(itype_word(OP_ADDI, 5'd2, 5'd0, 16'hfffd));
		put_instr(rtype_word(FN_ADD, 5'd3, 5'd1, 5'd2));
		put_instr(rtype_word(FN_SUB, 5'd4, 5'd3, 5'd1));
		put_instr(rtype_word(FN_AND, 5'd5, 5'd4, 5'd1));
		put_instr(rtype_word(FN_OR, 5'd6, 5'd5, 5'd3));
		put_instr(rtype_word(FN_SLT, 5'd7, 5'd2, 5'd6));
		put_instr(rtype_word(FN_SLT, 5'd8, 5'd6, 5'd2));
		put_instr(jump_word(8'd8));
		run_program();
	endtask

	task automatic load_store();
		start_test("loads and stores");
		put_instr(itype_word(OP_ADDI, 5'd1, 5'd0, 16'h0040));
		put_instr(itype_word(OP_ADDI, 5'd2, 5'd0, 16'h1234));
		put_instr(itype_word(OP_SW, 5'd2, 5'd1, 16'd0));
		put_instr(itype_word(OP_LW, 5'd3, 5'd1, 16'd0));
		// Load-use stall
		put_instr(rtype_word(FN_ADD, 5'd4, 5'd3, 5'd2));
		put_instr(itype_word(OP_LW, 5'd5, 5'd1, 16'd0));
		put_instr(itype_word(OP_SW, 5'd5, 5'd1, 16'd4));
		put_instr(itype_word(OP_ADDI, 5'd6, 5'd0, 16'h0077));
		put_instr(itype_word(OP_SW, 5'd6, 5'd1, 16'd8));
		put_instr(itype_word(OP_LW, 5'd7, 5'd1, 16'd4));
		put_instr(itype_word(OP_LW, 5'd8, 5'd1, 16'd8));
		put_instr(rtype_word(FN_ADD, 5'd9, 5'd7, 5'd8));
		put_instr(jump_word(8'd12));
		run_program();
	endtask

	task automatic branches();
		start_test("taken and not taken beq");
		put_instr(itype_word(OP_ADDI, 5'd1, 5'd0, 16'd7));
		put_instr(itype_word(OP_ADDI, 5'd2, 5'd0, 16'd7));
		put_instr(itype_word(OP_BEQ, 5'd2, 5'd1, 16'd3));
		put_instr(itype_word(OP_ADDI, 5'd3, 5'd0, 16'd1));
		put_instr(itype_word(OP_ADDI, 5'd4, 5'd0, 16'd2));
		put_instr(itype_word(OP_SW, 5'd1, 5'd0, 16'h0080));
		put_instr(itype_word(OP_ADDI, 5'd5, 5'd0, 16'd9));
		put_instr(itype_word(OP_BEQ, 5'd5, 5'd1, 16'd3));
		put_instr(itype_word(OP_ADDI, 5'd6, 5'd0, 16'd11));
		put_instr(itype_word(OP_SW, 5'd6, 5'd0, 16'h0084));
		put_instr(itype_word(OP_BEQ, 5'd6, 5'd6, 16'd2));
		put_instr(itype_word(OP_ADDI, 5'd7, 5'd0, 16'd1));
		put_instr(itype_word(OP_ADDI, 5'd8, 5'd0, 16'd1));
		put_instr(itype_word(OP_ADDI, 5'd9, 5'd0, 16'd5));
		put_instr(jump_word(8'd14));
		run_program();
	endtask

	task automatic jumps();
		start_test("jump and r0 writes");
		put_instr(itype_word(OP_ADDI, 5'd1, 5'd0, 16'd3));
		put_instr(jump_word(8'd5));
		put_instr(itype_word(OP_ADDI, 5'd2, 5'd0, 16'd1));
		put_instr(itype_word(OP_ADDI, 5'd3, 5'd0, 16'd1));
		put_instr(itype_word(OP_SW, 5'd1, 5'd0, 16'h0090));
		put_instr(rtype_word(FN_ADD, 5'd0, 5'd1, 5'd1));
		put_instr(itype_word(OP_ADDI, 5'd0, 5'd0, 16'd44));
		put_instr(rtype_word(FN_ADD, 5'd4, 5'd0, 5'd1));
		put_instr(jump_word(8'd8));
		run_program();
	endtask

	task automatic random_alu();
		word_t      rnd;
		logic [5:0] fn;
		start_test("random ALU program");
		for (int i = 0; i < 40; i++) begin
			rnd = $random(seed);
			case (rnd[11:9])
				3'd0:    fn = FN_ADD;
				3'd1:    fn = FN_SUB;
				3'd2:    fn = FN_AND;
				3'd3:    fn = FN_OR;
				default: fn = FN_SLT;
			endcase
			// Few registers so most instructions depend on recent ones
			if (rnd[11:9] > 3'd4)
				put_instr(itype_word(OP_ADDI, {2'b00, rnd[2:0]}, {2'b00, rnd[5:3]},
					rnd[31:16]));
			else
				put_instr(rtype_word(fn, {2'b00, rnd[2:0]}, {2'b00, rnd[5:3]},
					{2'b00, rnd[8:6]}));
		end
		put_instr(jump_word(8'd40));
		run_program();
	endtask

	initial begin
		rst_n = 1'b0;
		seed = 32'h897a_916c;
		alu_chain();
		load_store();
		branches();
		jumps();
		random_alu();
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
mips_pkg.sv
mips_fetch.sv
mips_decode.sv
mips_stage_reg.sv
mips_hazard.sv
mips_execute.sv
mips_dmem.sv
mips_pipe_top.sv
mips_pipe_props.sv
tb_mips_pipe.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the pipeline testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module tb_mips_pipe \
	-Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "tests failed" "$LOG"; then
	echo "Simulation reported a failure"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi
if ! grep -q "all tests passed" "$LOG"; then
	echo "Simulation ended without a result"
	exit 1
fi
exit 0
